// ==== src/calc_defines.svh ====
`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

// ========================================
// Datapath widths
// ========================================

// Operand and answer width.
`define CALC_WORD_W 16

// Width of the time-shared ALU.
`define CALC_BYTE_W 8

// ========================================
// Scan and display timing
// ========================================

// Clock cycles each keypad column stays driven.
`define CALC_SCAN_CYCLES 4

// Clock cycles each display digit stays lit.
`define CALC_DIGIT_CYCLES 8

`endif

// ==== src/CalcOpsPkg.sv ====
package CalcOpsPkg;

   // Low three bits of the operation key.
   typedef enum logic [2:0]
   {
      OpAdd  = 3'd0,
      OpSub  = 3'd1,
      OpAnd  = 3'd2,
      OpOr   = 3'd3,
      OpLess = 3'd4
   } KeyOp;

   // Function select of the byte ALU.
   typedef enum logic [2:0]
   {
      AluAdd  = 3'd0,
      AluSub  = 3'd1,
      AluAnd  = 3'd2,
      AluOr   = 3'd3,
      AluLess = 3'd4
   } AluFunc;

   function automatic AluFunc toAluFunc(input KeyOp op);
      case (op)
         OpSub:   return AluSub;
         OpAnd:   return AluAnd;
         OpOr:    return AluOr;
         OpLess:  return AluLess;
         default: return AluAdd;
      endcase
   endfunction

endpackage

// ==== src/CalcDataPkg.sv ====
`include "calc_defines.svh"

package CalcDataPkg;

   // One operand, seen whole or as two ALU bytes.
   typedef union packed
   {
      logic [`CALC_WORD_W-1:0] value;
      struct packed
      {
         logic [`CALC_BYTE_W-1:0] high;
         logic [`CALC_BYTE_W-1:0] low;
      } bytes;
   } OperandWord;

   typedef struct packed
   {
      logic negative;
      logic compare;
      logic zero;
      logic carry;
   } CalcFlags;

endpackage

// ==== src/ByteAlu.sv ====
`timescale 1ns/10ps
`include "calc_defines.svh"

module ByteAlu
(
   input  CalcOpsPkg::AluFunc aluFunc,
   input  logic [`CALC_BYTE_W-1:0] aluA,
   input  logic [`CALC_BYTE_W-1:0] aluB,
   input  logic aluCarryIn,
   output logic [`CALC_BYTE_W-1:0] aluSum,
   output logic aluCarryOut,
   output logic aluZero,
   output logic aluLess
);
   import CalcOpsPkg::*;

   logic [`CALC_BYTE_W:0] addResult;

   always_comb
   begin
      if (aluFunc == AluSub || aluFunc == AluLess)
         addResult = {1'b0, aluA} + {1'b0, ~aluB} + {{`CALC_BYTE_W{1'b0}}, aluCarryIn};
      else
         addResult = {1'b0, aluA} + {1'b0, aluB} + {{`CALC_BYTE_W{1'b0}}, aluCarryIn};
      case (aluFunc)
         AluAnd:
         begin
            aluSum = aluA & aluB;
            aluCarryOut = 1'b0;
         end
         AluOr:
         begin
            aluSum = aluA | aluB;
            aluCarryOut = 1'b0;
         end
         default:
         begin
            aluSum = addResult[`CALC_BYTE_W-1:0];
            aluCarryOut = addResult[`CALC_BYTE_W];  // High means no borrow on subtract.
         end
      endcase
   end

   // For compare the sum is A minus B, so zero marks equal bytes.
   assign aluZero = (aluSum == '0);
   assign aluLess = (aluA < aluB);

endmodule

// ==== src/KeyScanner.sv ====
`timescale 1ns/10ps
`include "calc_defines.svh"

module KeyScanner
(
   input  logic Clock,
   input  logic Reset,
   input  logic [3:0] H,
   output logic [3:0] V,
   output logic [`CALC_WORD_W-1:0] entryWord,
   output logic [`CALC_WORD_W-1:0] srcWord,
   output logic [`CALC_WORD_W-1:0] dstWord,
   output CalcOpsPkg::KeyOp keyOp,
   output logic useAnswer,
   output logic opReady,
   output logic keyAccepted
);
   import CalcOpsPkg::*;

   localparam int ScanLast = `CALC_SCAN_CYCLES - 1;
   localparam int TimerW = $clog2(`CALC_SCAN_CYCLES + 1);

   logic [TimerW-1:0] scanTimer;
   logic [3:0] hMeta;
   logic [3:0] hSync;
   logic [1:0] column;
   logic [1:0] row;
   logic [3:0] keyNum;
   logic [3:0] candKey;
   logic [3:0] keyCount;
   logic [2*`CALC_WORD_W-1:0] entryBuf;
   logic rowHit;
   logic visitEnd;
   logic candValid;
   logic released;
   logic scanAny;
   logic accept;
   logic opKeyValid;

   // ========================================
   // Column drive and row synchronizer
   // ========================================
   always_ff @(posedge Clock or negedge Reset)
   begin
      if (!Reset)
      begin
         scanTimer <= '0;
         V <= 4'b0111;
         hMeta <= 4'hF;
         hSync <= 4'hF;
      end
      else
      begin
         hMeta <= H;
         hSync <= hMeta;
         if (visitEnd)
         begin
            scanTimer <= '0;
            V <= {V[0], V[3:1]};                  // Column 0 sits at bit 3.
         end
         else
            scanTimer <= scanTimer + 1'b1;
      end
   end

   assign visitEnd = (scanTimer == TimerW'(ScanLast));
   assign rowHit = (hSync != 4'hF);
   assign keyNum = {row, column};

   always_comb
   begin
      case (V)
         4'b0111: column = 2'd0;
         4'b1011: column = 2'd1;
         4'b1101: column = 2'd2;
         default: column = 2'd3;
      endcase
      if (!hSync[3])
         row = 2'd0;
      else if (!hSync[2])
         row = 2'd1;
      else if (!hSync[1])
         row = 2'd2;
      else
         row = 2'd3;
   end

   // ========================================
   // Debounce with release lockout
   // ========================================
   assign accept = visitEnd && released && rowHit && candValid && (candKey == keyNum);

   always_ff @(posedge Clock or negedge Reset)
   begin
      if (!Reset)
      begin
         candKey <= '0;
         candValid <= 1'b0;
         released <= 1'b1;
         scanAny <= 1'b0;
      end
      else if (visitEnd)
      begin
         if (column == 2'd3)
         begin
            scanAny <= 1'b0;
            if (!scanAny && !rowHit)
               released <= 1'b1;                  // A whole scan went by with no key.
         end
         else
            scanAny <= scanAny | rowHit;
         if (accept)
         begin
            released <= 1'b0;
            candValid <= 1'b0;
         end
         else if (released && rowHit)
         begin
            candKey <= keyNum;
            candValid <= 1'b1;
         end
         else if (candKey[1:0] == column)
            candValid <= 1'b0;                    // Candidate was gone on its next visit.
      end
   end

   // ========================================
   // Entry of digits and operation key
   // ========================================
   assign opKeyValid = accept && (keyCount == 4'd8) && (keyNum[2:0] <= OpLess);
   assign entryWord = entryBuf[`CALC_WORD_W-1:0];

   always_ff @(posedge Clock or negedge Reset)
   begin
      if (!Reset)
      begin
         entryBuf <= '0;
         keyCount <= '0;
         opReady <= 1'b0;
         keyAccepted <= 1'b0;
      end
      else
      begin
         keyAccepted <= accept;
         opReady <= opKeyValid;
         if (opKeyValid)
         begin
            entryBuf <= '0;
            keyCount <= '0;
         end
         else if (accept && keyCount != 4'd8)
         begin
            entryBuf <= {entryBuf[2*`CALC_WORD_W-5:0], keyNum};
            keyCount <= keyCount + 1'b1;
         end
      end
   end

   always_ff @(posedge Clock)
   begin
      if (opKeyValid)
      begin
         srcWord <= entryBuf[2*`CALC_WORD_W-1:`CALC_WORD_W];
         dstWord <= entryBuf[`CALC_WORD_W-1:0];
         keyOp <= KeyOp'(keyNum[2:0]);
         useAnswer <= keyNum[3];                  // Keys 8 to C reuse the answer.
      end
   end

   // Two rows low in one column would be read as the upper row.
   OneRowOnAccept: assert property (@(posedge Clock) disable iff (!Reset)
      accept |-> $onehot(~hSync));

endmodule

// ==== src/WordSequencer.sv ====
`timescale 1ns/10ps
`include "calc_defines.svh"

module WordSequencer
(
   input  logic Clock,
   input  logic Reset,
   input  logic opReady,
   input  logic [`CALC_WORD_W-1:0] srcWord,
   input  logic [`CALC_WORD_W-1:0] dstWord,
   input  CalcOpsPkg::KeyOp keyOp,
   input  logic useAnswer,
   input  logic [`CALC_BYTE_W-1:0] aluSum,
   input  logic aluCarryOut,
   input  logic aluZero,
   input  logic aluLess,
   input  logic keyAccepted,
   output logic [`CALC_BYTE_W-1:0] aluA,
   output logic [`CALC_BYTE_W-1:0] aluB,
   output logic aluCarryIn,
   output CalcOpsPkg::AluFunc aluFunc,
   output logic [`CALC_WORD_W-1:0] answer,
   output CalcDataPkg::CalcFlags flags,
   output logic showAnswer
);
   import CalcOpsPkg::*;
   import CalcDataPkg::*;

   typedef enum logic [1:0] {SeqIdle, SeqLow, SeqHigh} SeqState;

   SeqState state;
   OperandWord opA;
   OperandWord opB;
   AluFunc func;
   logic [`CALC_BYTE_W-1:0] lowSum;
   logic carrySave;
   logic zeroSave;
   logic signsDiffer;
   logic lessBit;
   logic lessDone;

   assign signsDiffer = opA.bytes.high[`CALC_BYTE_W-1] ^ opB.bytes.high[`CALC_BYTE_W-1];
   assign lessBit = signsDiffer ? opA.bytes.high[`CALC_BYTE_W-1] : aluLess;
   assign lessDone = (func == AluLess) && (state == SeqLow || signsDiffer || !aluZero);
   assign aluFunc = func;

   // ========================================
   // ALU operand selection
   // ========================================
   always_comb
   begin
      if (state == SeqHigh)
      begin
         aluA = opA.bytes.high;
         aluB = opB.bytes.high;
      end
      else
      begin
         aluA = opA.bytes.low;
         aluB = opB.bytes.low;
      end
      if (state == SeqHigh && func != AluLess)
         aluCarryIn = carrySave;
      else
         aluCarryIn = (func == AluSub) || (func == AluLess);
   end

   always_ff @(posedge Clock or negedge Reset)
   begin
      if (!Reset)
      begin
         state <= SeqIdle;
         answer <= '0;
         flags <= '0;
         showAnswer <= 1'b0;
      end
      else
      begin
         if (opReady)
            showAnswer <= 1'b1;
         else if (keyAccepted)
            showAnswer <= 1'b0;
         case (state)
            SeqIdle:
               if (opReady)
                  state <= (toAluFunc(keyOp) == AluLess) ? SeqHigh : SeqLow;
            SeqLow, SeqHigh:
               if (lessDone)
               begin
                  state <= SeqIdle;
                  answer <= {{(`CALC_WORD_W-1){1'b0}}, lessBit};
                  flags <= '{negative: 1'b0, compare: lessBit, zero: 1'b0, carry: 1'b0};
               end
               else if (func == AluLess)
                  state <= SeqLow;                // High bytes equal, low byte decides.
               else if (state == SeqLow)
                  state <= SeqHigh;
               else
               begin
                  state <= SeqIdle;
                  answer <= {aluSum, lowSum};
                  flags <= '{negative: aluSum[`CALC_BYTE_W-1], compare: 1'b0,
                             zero: zeroSave & aluZero, carry: aluCarryOut};
               end
            default:
               state <= SeqIdle;
         endcase
      end
   end

   always_ff @(posedge Clock)
   begin
      if (opReady)
      begin
         opA.value <= useAnswer ? answer : srcWord;
         opB.value <= dstWord;
         func <= toAluFunc(keyOp);
      end
      if (state == SeqLow && func != AluLess)
      begin
         lowSum <= aluSum;
         carrySave <= aluCarryOut;                // Carried into the high byte.
         zeroSave <= aluZero;
      end
   end

   OpOnlyWhenIdle: assert property (@(posedge Clock) disable iff (!Reset)
      opReady |-> state == SeqIdle);

endmodule

// ==== src/DigitDisplay.sv ====
`timescale 1ns/10ps
`include "calc_defines.svh"

module DigitDisplay
(
   input  logic Clock,
   input  logic Reset,
   input  logic showAnswer,
   input  logic [`CALC_WORD_W-1:0] answer,
   input  logic [`CALC_WORD_W-1:0] entryWord,
   output logic [3:0] SD,
   output logic [7:0] SEG
);
   localparam int DigitLast = `CALC_DIGIT_CYCLES - 1;
   localparam int TimerW = $clog2(`CALC_DIGIT_CYCLES + 1);

   logic [TimerW-1:0] digitTimer;
   logic [`CALC_WORD_W-1:0] shown;
   logic [3:0] nibble;
   logic [6:0] segLit;

   always_ff @(posedge Clock or negedge Reset)
   begin
      if (!Reset)
      begin
         digitTimer <= '0;
         SD <= 4'b1000;                           // Most significant digit first.
      end
      else if (digitTimer == TimerW'(DigitLast))
      begin
         digitTimer <= '0;
         SD <= {SD[0], SD[3:1]};
      end
      else
         digitTimer <= digitTimer + 1'b1;
   end

   assign shown = showAnswer ? answer : entryWord;

   always_comb
   begin
      case (SD)
         4'b1000: nibble = shown[15:12];
         4'b0100: nibble = shown[11:8];
         4'b0010: nibble = shown[7:4];
         default: nibble = shown[3:0];
      endcase
      case (nibble)                               // Lit segments in g..a order.
         4'h0: segLit = 7'h3F;
         4'h1: segLit = 7'h06;
         4'h2: segLit = 7'h5B;
         4'h3: segLit = 7'h4F;
         4'h4: segLit = 7'h66;
         4'h5: segLit = 7'h6D;
         4'h6: segLit = 7'h7D;
         4'h7: segLit = 7'h07;
         4'h8: segLit = 7'h7F;
         4'h9: segLit = 7'h6F;
         4'hA: segLit = 7'h77;
         4'hB: segLit = 7'h7C;
         4'hC: segLit = 7'h39;
         4'hD: segLit = 7'h5E;
         4'hE: segLit = 7'h79;
         default: segLit = 7'h71;
      endcase
   end

   assign SEG = {1'b1, ~segLit};                  // Active low, dp kept dark.

endmodule

// ==== src/Calculator.sv ====
`timescale 1ns/10ps
`include "calc_defines.svh"

module Calculator
(
   input  logic Clock,
   input  logic Reset,
   input  logic [3:0] H,
   output logic [3:0] V,
   output logic [3:0] SD,
   output logic [7:0] SEG,
   output logic [7:0] LD
);
   import CalcOpsPkg::*;
   import CalcDataPkg::*;

   logic [`CALC_WORD_W-1:0] entryWord;
   logic [`CALC_WORD_W-1:0] srcWord;
   logic [`CALC_WORD_W-1:0] dstWord;
   logic [`CALC_WORD_W-1:0] answer;
   logic [`CALC_BYTE_W-1:0] aluA;
   logic [`CALC_BYTE_W-1:0] aluB;
   logic [`CALC_BYTE_W-1:0] aluSum;
   logic useAnswer;
   logic opReady;
   logic keyAccepted;
   logic showAnswer;
   logic aluCarryIn;
   logic aluCarryOut;
   logic aluZero;
   logic aluLess;
   KeyOp keyOp;
   AluFunc aluFunc;
   CalcFlags flags;

   assign LD = {flags, 4'b0000};                  // Flags on the upper four LEDs.

   KeyScanner keyScanner
   (
      .Clock(Clock), .Reset(Reset), .H(H), .V(V),
      .entryWord(entryWord), .srcWord(srcWord), .dstWord(dstWord),
      .keyOp(keyOp), .useAnswer(useAnswer), .opReady(opReady), .keyAccepted(keyAccepted)
   );

   WordSequencer wordSequencer
   (
      .Clock(Clock), .Reset(Reset), .opReady(opReady),
      .srcWord(srcWord), .dstWord(dstWord), .keyOp(keyOp), .useAnswer(useAnswer),
      .aluSum(aluSum), .aluCarryOut(aluCarryOut), .aluZero(aluZero), .aluLess(aluLess),
      .keyAccepted(keyAccepted), .aluA(aluA), .aluB(aluB), .aluCarryIn(aluCarryIn),
      .aluFunc(aluFunc), .answer(answer), .flags(flags), .showAnswer(showAnswer)
   );

   ByteAlu byteAlu
   (
      .aluFunc(aluFunc), .aluA(aluA), .aluB(aluB), .aluCarryIn(aluCarryIn),
      .aluSum(aluSum), .aluCarryOut(aluCarryOut), .aluZero(aluZero), .aluLess(aluLess)
   );

   DigitDisplay digitDisplay
   (
      .Clock(Clock), .Reset(Reset), .showAnswer(showAnswer),
      .answer(answer), .entryWord(entryWord), .SD(SD), .SEG(SEG)
   );

endmodule

// ==== testbench/CalculatorTb.sv ====
`timescale 1ns/10ps
`include "calc_defines.svh"

module CalculatorTb;

   localparam int NumOps = 16;
   localparam int ScanLen = 4 * `CALC_SCAN_CYCLES;        // Cycles for one full keypad scan.
   localparam int TimeLimit = NumOps * 10 * 6 * ScanLen * 4 * 2;

   logic Clock = 1'b0;
   logic Reset = 1'b0;
   logic [3:0] H = 4'hF;
   logic [3:0] V;
   logic [3:0] SD;
   logic [7:0] SEG;
   logic [7:0] LD;
   logic keyDown = 1'b0;
   logic [3:0] heldKey = 4'h0;
   logic [15:0] lastAnswer = 16'h0000;
   logic [3:0] lastFlags = 4'h0;

   Calculator dut_i (.Clock(Clock), .Reset(Reset), .H(H), .V(V), .SD(SD), .SEG(SEG), .LD(LD));

   initial
   begin
      forever #2 Clock = ~Clock;
   end

   // ========================================
   // Keypad model
   // ========================================
   always @(posedge Clock)
   begin
      #1;
      if (keyDown && V == ~(4'b1000 >> heldKey[1:0]))
         H <= ~(4'b1000 >> heldKey[3:2]);                // Row 0 sits at bit 3.
      else
         H <= 4'hF;
   end

   // ========================================
   // Checking helpers
   // ========================================
   task automatic stopWithFailure(input string why);
      $display("%s", why);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic checkValue(input string name, input logic [15:0] got,
                             input logic [15:0] expected);
      if (got !== expected)
         stopWithFailure($sformatf("Mismatch %s: got %h, expected %h", name, got, expected));
   endtask

   // Turns an active-low segment pattern back into a nibble; bit 4 marks no match.
   function automatic logic [4:0] segToNibble(input logic [7:0] seg);
      case (~seg)
         8'h3F: return 5'h00;
         8'h06: return 5'h01;
         8'h5B: return 5'h02;
         8'h4F: return 5'h03;
         8'h66: return 5'h04;
         8'h6D: return 5'h05;
         8'h7D: return 5'h06;
         8'h07: return 5'h07;
         8'h7F: return 5'h08;
         8'h6F: return 5'h09;
         8'h77: return 5'h0A;
         8'h7C: return 5'h0B;
         8'h39: return 5'h0C;
         8'h5E: return 5'h0D;
         8'h79: return 5'h0E;
         8'h71: return 5'h0F;
         default: return 5'h10;
      endcase
   endfunction

   task automatic readDisplay(output logic [15:0] word);
      logic [4:0] value;
      for (int d = 0; d < 4; d++)
      begin
         @(negedge Clock);
         while (SD != (4'b1000 >> d))
            @(negedge Clock);
         value = segToNibble(SEG);
         if (value[4])
            stopWithFailure("Display showed a segment pattern that is not a hex digit");
         word[15-4*d -: 4] = value[3:0];
      end
   endtask

   // Result in the low 16 bits with the flags negative, compare, zero and carry above it.
   function automatic logic [19:0] referenceResult(input logic [2:0] op, input logic [15:0] a,
                                                   input logic [15:0] b);
      logic [16:0] wide;
      logic less;
      wide = 17'd0;
      case (op)
         3'd0: wide = {1'b0, a} + {1'b0, b};
         3'd1: wide = {1'b0, a} + {1'b0, ~b} + 17'd1;   // Carry means no borrow.
         3'd2: wide = {1'b0, a & b};
         3'd3: wide = {1'b0, a | b};
         default:
         begin
            less = $signed(a) < $signed(b);
            return {1'b0, less, 1'b0, 1'b0, 15'd0, less};
         end
      endcase
      return {wide[15], 1'b0, wide[15:0] == 16'd0, wide[16], wide[15:0]};
   endfunction

   // ========================================
   // Stimulus
   // ========================================
   task automatic pressKey(input logic [3:0] key, output logic [15:0] shown);
      @(posedge Clock);
      heldKey = key;
      keyDown = 1'b1;
      repeat (ScanLen * 3) @(posedge Clock);
      keyDown = 1'b0;
      fork
         repeat (ScanLen * 3) @(posedge Clock);
         readDisplay(shown);
      join
      @(negedge Clock);
   endtask

   task automatic typeOperation(input logic [15:0] a, input logic [15:0] b,
                                input logic [3:0] opKey, input logic badKeyFirst);
      logic [31:0] operands;
      logic [31:0] entry;
      logic [15:0] shown;
      logic [19:0] model;
      logic [3:0] digit;
      logic [3:0] badKey;
      operands = {a, b};
      entry = 32'd0;
      for (int i = 0; i < 8; i++)
      begin
         digit = operands[31-4*i -: 4];
         entry = {entry[27:0], digit};
         pressKey(digit, shown);
         checkValue("entry display", shown, entry[15:0]);
      end
      if (badKeyFirst)
      begin
         badKey[3] = 1'($urandom_range(1, 0));
         badKey[2:0] = 3'($urandom_range(7, 5));     // Low bits 5 to 7 are no operation.
         pressKey(badKey, shown);
         checkValue("display after invalid key", shown, entry[15:0]);
         checkValue("LD after invalid key", {8'h00, LD}, {8'h00, lastFlags, 4'h0});
      end
      model = referenceResult(opKey[2:0], opKey[3] ? lastAnswer : a, b);
      pressKey(opKey, shown);
      lastAnswer = model[15:0];
      lastFlags = model[19:16];
      checkValue("answer display", shown, lastAnswer);
      checkValue("LD", {8'h00, LD}, {8'h00, lastFlags, 4'h0});
   endtask

   initial
   begin
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] shown;
      logic [3:0] opKey;
      logic badKey;
      void'($urandom(32'h3df5));
      Reset = 1'b0;
      repeat (8) @(posedge Clock);
      #1 Reset = 1'b1;
      checkValue("V after reset", {12'h000, V}, 16'h0007);
      checkValue("SD after reset", {12'h000, SD}, 16'h0008);
      readDisplay(shown);
      checkValue("display after reset", shown, 16'h0000);
      checkValue("LD after reset", {8'h00, LD}, 16'h0000);
      for (int i = 0; i < NumOps; i++)
      begin
         a = 16'($urandom);
         b = 16'($urandom);
         badKey = 1'b0;
         case (i / 4)
            0:
            begin
               opKey = 4'(i % 2);
               if (i == 3)
                  b = a;                                  // Subtract to zero.
            end
            1:
            begin
               opKey = 4'(2 + i % 2);
               if (i == 4)
                  b = ~a;
               if (i == 5)
               begin
                  a = 16'h0000;
                  b = 16'h0000;
               end
            end
            2:
            begin
               opKey = 4'h4;
               if (i == 9)
                  b[15:8] = a[15:8];
               if (i == 10)
                  b[15] = ~a[15];
               if (i == 11)
                  b = a;
            end
            default:
            begin
               opKey = 4'(8 + $urandom_range(4, 0));   // Chain from the previous answer.
               badKey = (i == 13 || i == 15);
            end
         endcase
         typeOperation(a, b, opKey, badKey);
      end
      $display("Testbench passed");
      $finish;
   end

   initial
   begin
      #(TimeLimit);
      stopWithFailure("Run timed out before all operations were checked");
   end

endmodule

// ==== sources.f ====
+incdir+src
src/CalcOpsPkg.sv
src/CalcDataPkg.sv
src/ByteAlu.sv
src/KeyScanner.sv
src/WordSequencer.sv
src/DigitDisplay.sv
src/Calculator.sv
testbench/CalculatorTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module CalculatorTb \
   -Mdir obj_dir -o CalculatorTb
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/CalculatorTb
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit 1
fi

echo "Simulation finished"
exit 0
